// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       := ex_stage_tb
FILELIST  := build.f
LOG       := sim.log
EXE       := Vex_stage_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(EXE)
	-./obj_dir/$(EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// expected values for the execute stage, built from the stage rules

// sign-extend a 32-bit word result
function automatic logic [63:0] ref_sext32(input logic [31:0] w);
    return {{32{w[31]}}, w};
endfunction

// newest writer wins, x0 is hardwired
function automatic logic [63:0] ref_src(
    input logic [4:0]  idx,
    input logic [63:0] issued,
    input fwd_src_t    mem_src,
    input fwd_src_t    wb_src
);
    if (idx == 5'd0) begin
        return issued;
    end
    if (mem_src.writing && (mem_src.rd == idx)) begin
        return mem_src.data;
    end
    if (wb_src.writing && (wb_src.rd == idx)) begin
        return wb_src.data;
    end
    return issued;
endfunction

// only these classes read rs2
function automatic logic ref_reads_rs2(input op_class_e cls);
    return (cls == cls_branch) || (cls == cls_store) || (cls == cls_op) || (cls == cls_op_w);
endfunction

// integer result per class and funct3
function automatic logic [63:0] ref_alu_out(
    input ex_issue_t   it,
    input logic [63:0] s1,
    input logic [63:0] s2
);
    logic [63:0] b;
    logic        alt;
    logic [31:0] lo;
    alt = it.imm[10];
    case (it.op_class)
        cls_lui:              return it.imm;
        cls_auipc:            return it.pc + it.imm;
        cls_jal, cls_jalr:    return it.pc + 64'd4;
        cls_load, cls_store:  return s1 + it.imm;
        // compare subtract
        cls_branch:           return s1 - s2;
        cls_op, cls_op_imm: begin
            b = (it.op_class == cls_op) ? s2 : it.imm;
            case (it.funct3)
                3'b000: return (alt && it.op_class == cls_op) ? s1 - b : s1 + b;
                3'b001: return s1 << b[5:0];
                3'b010: return {63'd0, $signed(s1) < $signed(b)};
                3'b011: return {63'd0, s1 < b};
                3'b100: return s1 ^ b;
                3'b101: return alt ? 64'($signed(s1) >>> b[5:0]) : s1 >> b[5:0];
                3'b110: return s1 | b;
                default: return s1 & b;
            endcase
        end
        cls_op_w, cls_op_imm_w: begin
            b = (it.op_class == cls_op_w) ? s2 : it.imm;
            case (it.funct3)
                3'b000: lo = (alt && it.op_class == cls_op_w) ? s1[31:0] - b[31:0]
                                                              : s1[31:0] + b[31:0];
                3'b001: lo = s1[31:0] << b[4:0];
                default: lo = alt ? 32'($signed(s1[31:0]) >>> b[4:0]) : s1[31:0] >> b[4:0];
            endcase
            return ref_sext32(lo);
        end
        default: return s1 + s2;
    endcase
endfunction

// redirect against backward-taken static prediction
function automatic redirect_t ref_redirect(
    input ex_issue_t   it,
    input logic [63:0] s1,
    input logic [63:0] s2
);
    redirect_t r;
    logic      taken;
    r.update = 1'b0;
    r.dnpc   = it.pc + 64'd4;
    case (it.funct3)
        3'b000:  taken = (s1 == s2);
        3'b001:  taken = (s1 != s2);
        3'b100:  taken = ($signed(s1) < $signed(s2));
        3'b101:  taken = !($signed(s1) < $signed(s2));
        3'b110:  taken = (s1 < s2);
        default: taken = !(s1 < s2);
    endcase
    if (it.op_class == cls_jalr) begin
        r.update = 1'b1;
        r.dnpc   = s1 + it.imm;
    end else if (it.op_class == cls_branch) begin
        r.update = (taken != it.imm[12]);
        r.dnpc   = it.imm[12] ? it.pc + 64'd4 : it.pc + it.imm;
    end
    return r;
endfunction

`endif

// File: bench/ex_stage_tb.sv
`timescale 1ns/100ps

module ex_stage_tb
    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;
();

    `include "ex_ref_model.svh"

    localparam int NUM_CHECKS  = 2000;
    localparam int CYCLE_LIMIT = 20000;

    logic       clk = 1'b0;
    logic       arst_n = 1'b0;
    logic       flush = 1'b0;
    logic       id_valid = 1'b0;
    logic       id_ready;
    ex_issue_t  id_issue = '0;
    fwd_src_t   mem_fwd = '0;
    fwd_src_t   wb_fwd = '0;
    logic       mem_valid;
    logic       mem_ready = 1'b1;
    ex_result_t mem_result;
    redirect_t  redirect;

    integer     seed = 32'hfab8148e;
    int         checked = 0;

    // tb copy of the stage register
    logic       model_valid = 1'b0;
    ex_issue_t  model_issue = '0;
    logic       held = 1'b0;
    ex_result_t last_result = '0;

    ex_stage UUT (.*);

    always #20 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("ERR %s got %h expected %h", name, got, exp);
        $display("sim failed");
        $fatal(1, "mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "failure");
    endtask

    // small register indices so forwarding hits often, x0 included
    task automatic drive_random_inputs();
        op_class_e cls_list [10] = '{cls_lui, cls_auipc, cls_jalr, cls_branch, cls_load,
                                     cls_store, cls_op_imm, cls_op, cls_op_imm_w, cls_op_w};
        ex_issue_t it;
        logic      prev_ready;
        prev_ready = mem_ready;
        it.op_class = cls_list[{$random(seed)} % 10];
        it.pc       = {$random(seed), $random(seed) & 32'hfffffffc};
        it.funct3   = 3'($random(seed));
        it.rd       = 5'($random(seed));
        it.rs1      = 5'({$random(seed)} % 4);
        it.rs2      = 5'({$random(seed)} % 4);
        it.src_a    = {$random(seed), $random(seed)};
        it.src_b    = (({$random(seed)} % 4) == 0) ? it.src_a : {$random(seed), $random(seed)};
        it.imm      = 64'($signed(12'($random(seed))));
        if (it.op_class == cls_branch) begin
            // 13-bit offset, bit 12 is the sign
            it.imm = 64'($signed({12'($random(seed)), 1'b0}));
            if (it.funct3 inside {3'b010, 3'b011}) begin
                it.funct3 = 3'b000;
            end
        end else if (it.op_class inside {cls_op_w, cls_op_imm_w}) begin
            // only addw, sllw, srlw and sraw exist
            it.funct3 = (it.funct3[0]) ? (it.funct3[2] ? 3'b101 : 3'b001) : 3'b000;
        end else if (it.op_class == cls_lui) begin
            it.imm = 64'($signed({20'($random(seed)), 12'd0}));
        end
        id_issue  = it;
        id_valid  = ({$random(seed)} % 8) != 0;
        flush     = ({$random(seed)} % 16) == 0;
        mem_ready = ({$random(seed)} % 4) != 0;
        // a held slot sees the same bypass values
        if (prev_ready) begin
            mem_fwd = '{writing: 1'($random(seed)), rd: 5'({$random(seed)} % 4),
                        data: {$random(seed), $random(seed)}};
            wb_fwd  = '{writing: 1'($random(seed)), rd: 5'({$random(seed)} % 4),
                        data: {$random(seed), $random(seed)}};
        end
    endtask

    // compare, then advance the register copy
    always @(posedge clk) begin : compare_proc
        logic [63:0] s1;
        logic [63:0] s2;
        redirect_t   exp_r;
        if (!arst_n) begin
            assert (mem_valid == 1'b0) else report_mismatch("mem_valid", mem_valid, 0);
            model_valid = 1'b0;
            held        = 1'b0;
        end else begin
            assert (mem_valid == model_valid)
                else report_mismatch("mem_valid", mem_valid, model_valid);
            if (!mem_ready) begin
                assert (id_ready == 1'b0) else report_mismatch("id_ready", id_ready, 0);
                assert (redirect.update == 1'b0)
                    else report_mismatch("redirect.update", redirect.update, 0);
            end
            if (held) begin
                assert (mem_result == last_result)
                    else report_failure("mem_result changed while the stage was held");
            end
            if (model_valid && mem_ready) begin
                s1 = ref_src(model_issue.rs1, model_issue.src_a, mem_fwd, wb_fwd);
                s2 = ref_reads_rs2(model_issue.op_class) ?
                     ref_src(model_issue.rs2, model_issue.src_b, mem_fwd, wb_fwd) :
                     model_issue.src_b;
                assert (mem_result.alu_out == ref_alu_out(model_issue, s1, s2))
                    else report_mismatch("alu_out", mem_result.alu_out,
                                         ref_alu_out(model_issue, s1, s2));
                assert (mem_result.store_data == s2)
                    else report_mismatch("store_data", mem_result.store_data, s2);
                assert (mem_result.rd == model_issue.rd)
                    else report_mismatch("rd", 64'(mem_result.rd), 64'(model_issue.rd));
                // pass-through fields for the memory stage
                assert (mem_result.pc == model_issue.pc)
                    else report_mismatch("pc", mem_result.pc, model_issue.pc);
                assert (mem_result.op_class == model_issue.op_class)
                    else report_mismatch("op_class", 64'(mem_result.op_class),
                                         64'(model_issue.op_class));
                assert (mem_result.funct3 == model_issue.funct3)
                    else report_mismatch("funct3", 64'(mem_result.funct3),
                                         64'(model_issue.funct3));
                assert (mem_result.rs2 == model_issue.rs2)
                    else report_mismatch("rs2", 64'(mem_result.rs2), 64'(model_issue.rs2));
                exp_r = ref_redirect(model_issue, s1, s2);
                assert (redirect.update == exp_r.update)
                    else report_mismatch("redirect.update", redirect.update, exp_r.update);
                if (exp_r.update) begin
                    assert (redirect.dnpc == exp_r.dnpc)
                        else report_mismatch("redirect.dnpc", redirect.dnpc, exp_r.dnpc);
                end
                checked++;
            end
            held        = model_valid && !mem_ready && !flush;
            last_result = mem_result;
            if (flush) begin
                model_valid = 1'b0;
            end else if (mem_ready) begin
                model_valid = id_valid;
                model_issue = id_issue;
            end
        end
    end

    initial begin : stimulus_proc
        int cycles;
        repeat (5) @(posedge clk);
        #2 arst_n = 1'b1;
        cycles = 0;
        while (checked < NUM_CHECKS && cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            #2 drive_random_inputs();
            cycles++;
        end
        if (cycles >= CYCLE_LIMIT) begin
            report_failure("timeout waiting for enough checked results");
        end
        // drain with bubbles, then expect an empty stage
        id_valid  = 1'b0;
        flush     = 1'b0;
        mem_ready = 1'b1;
        cycles    = 0;
        while (mem_valid && cycles < 10) begin
            @(posedge clk);
            #2 cycles++;
        end
        if (mem_valid) begin
            report_failure("timeout waiting for the stage to drain");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// File: build.f
source/ex_isa_pkg.sv
source/ex_pipe_pkg.sv
source/ex_issue_reg.sv
source/ex_operand_sel.sv
source/ex_alu.sv
source/ex_branch_unit.sv
source/ex_stage.sv
+incdir+bench
bench/ex_stage_tb.sv

// File: source/ex_alu.sv
`timescale 1ns/100ps

module ex_alu
    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;
(
    input  alu_req_t        alu_req,
    output logic [XLEN-1:0] result
);

    logic [XLEN-1:0]    a;
    logic [XLEN-1:0]    b;
    logic [XLEN-1:0]    shift_in;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    raw;

    assign a = alu_req.operand_a;
    assign b = alu_req.operand_b;

    // operand_b already masked upstream for shifts
    assign shamt = b[SHAMT_W-1:0];

    // word right shifts see only the low word
    // zero-extended for srl, sign-extended for sra
    always_comb begin
        if (!alu_req.word) begin
            shift_in = a;
        end else if (alu_req.op == alu_sra) begin
            shift_in = {{(XLEN-32){a[31]}}, a[31:0]};
        end else begin
            shift_in = {{(XLEN-32){1'b0}}, a[31:0]};
        end
    end

    // full width operation
    // low word of add, sub, sll is already the word result
    always_comb begin
        case (alu_req.op)
            alu_add:  raw = a + b;
            alu_sub:  raw = a - b;
            alu_slt:  raw = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: raw = {{(XLEN-1){1'b0}}, a < b};
            alu_and:  raw = a & b;
            alu_or:   raw = a | b;
            alu_xor:  raw = a ^ b;
            alu_sll:  raw = shift_in << shamt;
            alu_srl:  raw = shift_in >> shamt;
            alu_sra:  raw = $signed(shift_in) >>> shamt;
            default:  raw = a + b;
        endcase
    end

    // word results sign-extended from bit 31
    assign result = alu_req.word ? {{(XLEN-32){raw[31]}}, raw[31:0]} : raw;

    // memory stage relies on canonical word values
    always_comb begin
        if (alu_req.word) begin
            a_word_sext: assert (result[XLEN-1:32] == {(XLEN-32){result[31]}})
                else $error("word result not sign-extended");
        end
    end

endmodule

// File: source/ex_branch_unit.sv
`timescale 1ns/100ps

module ex_branch_unit
    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;
(
    input  logic            valid,
    input  logic            mem_ready,
    input  ex_issue_t       issue,
    input  logic [XLEN-1:0] src1,
    input  logic [XLEN-1:0] src2,
    output redirect_t       redirect
);

    logic            cond;
    logic            backward;
    logic [XLEN-1:0] snpc;
    logic [XLEN-1:0] target;

    // compare straight on the forwarded operands
    always_comb begin
        case (issue.funct3)
            f3_beq:  cond = src1 == src2;
            f3_bne:  cond = src1 != src2;
            f3_blt:  cond = $signed(src1) < $signed(src2);
            f3_bge:  cond = $signed(src1) >= $signed(src2);
            f3_bltu: cond = src1 < src2;
            f3_bgeu: cond = src1 >= src2;
            default: cond = 1'b0;
        endcase
    end

    // fetch already went to target for backward offsets
    assign backward = issue.imm[12];
    assign snpc     = issue.pc + XLEN'(INST_BYTES);
    assign target   = issue.pc + issue.imm;

    always_comb begin
        redirect.update = 1'b0;
        redirect.dnpc   = snpc;
        if (issue.op_class == cls_jalr) begin
            redirect.update = 1'b1;
            redirect.dnpc   = src1 + issue.imm;
        end else if (issue.op_class == cls_branch) begin
            // mispredict when outcome disagrees with the static guess
            redirect.update = cond != backward;
            // wrong guess on backward means fall through
            redirect.dnpc   = backward ? snpc : target;
        end
        // only a slot that leaves this cycle may steer fetch
        if (!(valid && mem_ready)) begin
            redirect.update = 1'b0;
        end
    end

    // no redirect from an empty slot
    always_comb begin
        a_update_valid: assert (!redirect.update || valid)
            else $error("redirect from invalid slot");
    end

endmodule

// File: source/ex_isa_pkg.sv
package ex_isa_pkg;

    // datapath and register file geometry
    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;

    // fall-through step, also the link offset for jal/jalr
    localparam int INST_BYTES = 4;

    // shift amount widths, doubleword and word forms
    localparam int SHAMT_W      = 6;
    localparam int SHAMT_W_WORD = 5;

    // instruction class as handed over by decode
    typedef enum logic [3:0] {
        cls_none,
        cls_lui,
        cls_auipc,
        cls_jal,
        cls_jalr,
        cls_branch,
        cls_load,
        cls_store,
        cls_op_imm,
        cls_op,
        cls_op_imm_w,
        cls_op_w
    } op_class_e;

    // alu operations
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    // branch compare selects
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // integer op selects, srl and sra share one code
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

endpackage

// File: source/ex_issue_reg.sv
`timescale 1ns/100ps

module ex_issue_reg
    import ex_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      flush,
    input  logic      id_valid,
    input  logic      id_ready,
    input  ex_issue_t id_issue,
    output logic      valid,
    output ex_issue_t issue
);

    // valid bit
    // flush beats a transfer on the same edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (id_ready) begin
            // bubble from decode copied in as is
            valid <= id_valid;
        end
    end

    // payload
    // only moves when the stage accepts
    // stale content under a cleared valid is harmless
    always_ff @(posedge clk) begin
        if (id_ready) begin
            issue <= id_issue;
        end
    end

    // a flushed slot never reaches memory
    a_flush_clears: assert property (
        @(posedge clk) disable iff (!arst_n)
        flush |=> !valid
    ) else $error("valid still set after flush");

endmodule

// File: source/ex_operand_sel.sv
`timescale 1ns/100ps

module ex_operand_sel
    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;
(
    input  logic            valid,
    input  ex_issue_t       issue,
    input  fwd_src_t        mem_fwd,
    input  fwd_src_t        wb_fwd,
    output logic [XLEN-1:0] src1,
    output logic [XLEN-1:0] src2,
    output alu_req_t        alu_req
);

    logic            uses_rs2;
    logic            alt;
    logic            word;
    alu_op_e         op;
    logic [XLEN-1:0] opnd_b;

    // memory over writeback over issued value, x0 never bypassed
    function automatic logic [XLEN-1:0] fwd_pick(
        input logic [REG_ADDR_W-1:0] idx,
        input logic [XLEN-1:0]       issued,
        input fwd_src_t              mem_src,
        input fwd_src_t              wb_src
    );
        logic [XLEN-1:0] pick;
        pick = issued;
        if (idx != '0) begin
            if (mem_src.writing && mem_src.rd == idx) begin
                pick = mem_src.data;
            end else if (wb_src.writing && wb_src.rd == idx) begin
                pick = wb_src.data;
            end
        end
        return pick;
    endfunction

    // classes that really read rs2
    assign uses_rs2 = issue.op_class inside {cls_branch, cls_store, cls_op, cls_op_w};

    // empty slot gives zero operands
    assign src1 = valid ? fwd_pick(issue.rs1, issue.src_a, mem_fwd, wb_fwd) : '0;
    assign src2 = !valid   ? '0 :
                  uses_rs2 ? fwd_pick(issue.rs2, issue.src_b, mem_fwd, wb_fwd) :
                             issue.src_b;

    // instruction bit 30
    assign alt  = issue.imm[10];
    assign word = issue.op_class inside {cls_op_imm_w, cls_op_w};

    // operation decode
    always_comb begin
        op = alu_add;
        if (issue.op_class == cls_branch) begin
            op = alu_sub;
        end else if (issue.op_class inside {cls_op_imm, cls_op, cls_op_imm_w, cls_op_w}) begin
            case (issue.funct3)
                // addi never subtracts, its bit 30 is immediate
                f3_add:  op = (alt && issue.op_class inside {cls_op, cls_op_w}) ? alu_sub : alu_add;
                f3_sll:  op = alu_sll;
                f3_slt:  op = alu_slt;
                f3_sltu: op = alu_sltu;
                f3_xor:  op = alu_xor;
                f3_sr:   op = alt ? alu_sra : alu_srl;
                f3_or:   op = alu_or;
                f3_and:  op = alu_and;
                default: op = alu_add;
            endcase
        end
    end

    // operand b before shift masking
    always_comb begin
        if (issue.op_class inside {cls_jal, cls_jalr}) begin
            // link value pc + 4
            opnd_b = XLEN'(INST_BYTES);
        end else if (issue.op_class inside {cls_lui, cls_auipc, cls_load, cls_store,
                                            cls_op_imm, cls_op_imm_w}) begin
            opnd_b = issue.imm;
        end else begin
            opnd_b = src2;
        end
    end

    // request to the alu
    always_comb begin
        alu_req.op   = op;
        alu_req.word = word;
        // operand a, zero for lui, pc for the pc-relative classes
        if (issue.op_class == cls_lui) begin
            alu_req.operand_a = '0;
        end else if (issue.op_class inside {cls_auipc, cls_jal, cls_jalr}) begin
            alu_req.operand_a = issue.pc;
        end else begin
            alu_req.operand_a = src1;
        end
        // shamt only, drops funct7 bits of the immediate
        if (op inside {alu_sll, alu_srl, alu_sra}) begin
            alu_req.operand_b = word ? XLEN'(opnd_b[SHAMT_W_WORD-1:0])
                                     : XLEN'(opnd_b[SHAMT_W-1:0]);
        end else begin
            alu_req.operand_b = opnd_b;
        end
    end

endmodule

// File: source/ex_pipe_pkg.sv
package ex_pipe_pkg;

    import ex_isa_pkg::*;

    // decode to execute payload
    // imm[10] is instruction bit 30, imm[12] the branch offset sign
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        op_class_e             op_class;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       src_a;
        logic [XLEN-1:0]       src_b;
        logic [XLEN-1:0]       imm;
    } ex_issue_t;

    // result bypass from a later stage
    typedef struct packed {
        logic                  writing;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } fwd_src_t;

    // alu request, word selects the 32-bit form
    typedef struct packed {
        alu_op_e         op;
        logic            word;
        logic [XLEN-1:0] operand_a;
        logic [XLEN-1:0] operand_b;
    } alu_req_t;

    // execute to memory payload
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        op_class_e             op_class;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       alu_out;
        logic [XLEN-1:0]       store_data;
    } ex_result_t;

    // fetch redirect
    typedef struct packed {
        logic            update;
        logic [XLEN-1:0] dnpc;
    } redirect_t;

endpackage

// File: source/ex_stage.sv
`timescale 1ns/100ps

module ex_stage
    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       flush,
    input  logic       id_valid,
    output logic       id_ready,
    input  ex_issue_t  id_issue,
    input  fwd_src_t   mem_fwd,
    input  fwd_src_t   wb_fwd,
    output logic       mem_valid,
    input  logic       mem_ready,
    output ex_result_t mem_result,
    output redirect_t  redirect
);

    logic            valid;
    ex_issue_t       issue;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    alu_req_t        alu_req;
    logic [XLEN-1:0] alu_result;

    // single cycle stage, never busy on its own
    assign id_ready = mem_ready;

    ex_issue_reg u_issue_reg (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .id_valid (id_valid),
        .id_ready (id_ready),
        .id_issue (id_issue),
        .valid    (valid),
        .issue    (issue)
    );

    ex_operand_sel u_operand_sel (
        .valid   (valid),
        .issue   (issue),
        .mem_fwd (mem_fwd),
        .wb_fwd  (wb_fwd),
        .src1    (src1),
        .src2    (src2),
        .alu_req (alu_req)
    );

    ex_alu u_alu (
        .alu_req (alu_req),
        .result  (alu_result)
    );

    ex_branch_unit u_branch_unit (
        .valid     (valid),
        .mem_ready (mem_ready),
        .issue     (issue),
        .src1      (src1),
        .src2      (src2),
        .redirect  (redirect)
    );

    // to memory
    assign mem_valid = valid;

    // alu_out doubles as address, link value or upper immediate
    assign mem_result.pc         = issue.pc;
    assign mem_result.op_class   = issue.op_class;
    assign mem_result.funct3     = issue.funct3;
    assign mem_result.rd         = issue.rd;
    assign mem_result.rs2        = issue.rs2;
    assign mem_result.alu_out    = alu_result;
    // forwarded rs2 value for stores
    assign mem_result.store_data = src2;

endmodule
